//--- compile.f
source/i2c_pkg.sv
source/bus_pkg.sv
source/i2c_line_sampler.sv
source/i2c_byte_receiver.sv
source/i2c_sda_driver.sv
source/i2c_transfer_ctrl.sv
source/reg_bus_master.sv
source/i2c_slave_top.sv
dv/i2c_slave_sva.sv
dv/tb_i2c_slave.sv

//--- Bender.yml
package:
  name: i2c_slave

sources:
  - source/i2c_pkg.sv
  - source/bus_pkg.sv
  - source/i2c_line_sampler.sv
  - source/i2c_byte_receiver.sv
  - source/i2c_sda_driver.sv
  - source/i2c_transfer_ctrl.sv
  - source/reg_bus_master.sv
  - source/i2c_slave_top.sv
  - target: test
    files:
      - dv/i2c_slave_sva.sv
      - dv/tb_i2c_slave.sv

//--- dv/tb_i2c_slave.sv
// I2C master model, register memory model and random write, read and wrong address traffic
// SCL high and low phases are 16 clocks each, all stimulus changes on the falling clock edge

module tb_i2c_slave;

    import i2c_pkg::*;
    import bus_pkg::*;

    // ----------------------------------------
    // Run length
    // ----------------------------------------
    localparam int QUARTER_SCL = 8;
    localparam int HALF_SCL    = 2 * QUARTER_SCL;
    localparam int NUM_ROUNDS  = 10;
    localparam int NUM_XFERS   = 3 * NUM_ROUNDS;
    localparam int MAX_BYTES   = 4;
    // Bytes plus overhead, nine bits each, one SCL period per bit, margin of two
    localparam int CYCLE_LIMIT = NUM_XFERS * (MAX_BYTES + 2) * 9 * (2 * HALF_SCL) * 2;

    logic      i_clk;
    logic      i_reset;
    logic      i_scl;
    logic      i_sda;
    bus_data_t i_bus_data;
    logic      o_sda_oe;
    logic      o_bus_cs;
    logic      o_bus_wr;
    bus_addr_t o_bus_addr;
    bus_data_t o_bus_data;

    // Master side of the wired-AND SDA line
    logic      sda_drive;
    integer    seed;
    int        cycle_cnt = 0;
    // Register memory model and observed bus writes
    bus_data_t mem [0:255];
    bus_addr_t wr_addr_q[$];
    bus_data_t wr_data_q[$];
    logic      bus_seen;

    // Slave pulls the line low whenever o_sda_oe is high
    assign i_sda = sda_drive & ~o_sda_oe;

    i2c_slave_top uut
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_scl      (i_scl),
        .i_sda      (i_sda),
        .i_bus_data (i_bus_data),
        .o_sda_oe   (o_sda_oe),
        .o_bus_cs   (o_bus_cs),
        .o_bus_wr   (o_bus_wr),
        .o_bus_addr (o_bus_addr),
        .o_bus_data (o_bus_data)
    );

    always #4 i_clk = ~i_clk;

    // Memory model, writes recorded and read data answered on the falling edge
    always @(negedge i_clk)
    begin
        if (o_bus_wr)
        begin
            mem[o_bus_addr] = o_bus_data;
            wr_addr_q.push_back(o_bus_addr);
            wr_data_q.push_back(o_bus_data);
        end
        if (o_bus_cs)
            bus_seen = 1'b1;
        i_bus_data = mem[o_bus_addr];
    end

    // ----------------------------------------
    // Run limits
    // ----------------------------------------
    always @(posedge i_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout, the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    // Bound assertions count their failures
    always @(negedge i_clk)
    begin
        if (uut.u_sva.fail_count != 0)
        begin
            $display("A bound assertion on the bus strobes or SDA drive failed");
            $display("Test failed");
            $fatal(1, "Assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic check_idle();
        check_value("o_bus_cs", o_bus_cs, 1'b0);
        check_value("o_bus_wr", o_bus_wr, 1'b0);
        check_value("o_sda_oe", o_sda_oe, 1'b0);
    endtask

    // ----------------------------------------
    // I2C master model
    // ----------------------------------------
    // Every bus task starts and ends right after an SCL fall, or with the bus idle
    task automatic issue_start();
        wait_clocks(QUARTER_SCL);
        sda_drive = 1'b1;
        wait_clocks(QUARTER_SCL);
        i_scl = 1'b1;
        wait_clocks(QUARTER_SCL);
        // SDA falls in the middle of the high phase
        sda_drive = 1'b0;
        wait_clocks(QUARTER_SCL);
        i_scl = 1'b0;
    endtask

    task automatic issue_stop();
        wait_clocks(QUARTER_SCL);
        sda_drive = 1'b0;
        wait_clocks(QUARTER_SCL);
        i_scl = 1'b1;
        wait_clocks(QUARTER_SCL);
        sda_drive = 1'b1;
        // Bus free time, also lets the slave settle in idle
        wait_clocks(HALF_SCL);
    endtask

    // One SCL period, SDA set mid-low and sampled mid-high
    task automatic clock_bit(input logic bit_in, output logic bit_out);
        wait_clocks(QUARTER_SCL);
        sda_drive = bit_in;
        wait_clocks(QUARTER_SCL);
        i_scl = 1'b1;
        wait_clocks(QUARTER_SCL);
        bit_out = i_sda;
        wait_clocks(QUARTER_SCL);
        i_scl = 1'b0;
    endtask

    task automatic send_byte(input bus_data_t data, output logic ack_bit);
        logic unused_bit;
        for (int i = BITS_PER_BYTE - 1; i >= 0; i--)
            clock_bit(data[i], unused_bit);
        // Release SDA for the slave's acknowledge
        clock_bit(1'b1, ack_bit);
    endtask

    task automatic recv_byte(input logic ack_bit, output bus_data_t data);
        logic sda_bit;
        logic unused_bit;
        for (int i = BITS_PER_BYTE - 1; i >= 0; i--)
        begin
            clock_bit(1'b1, sda_bit);
            data[i] = sda_bit;
        end
        clock_bit(ack_bit, unused_bit);
    endtask

    // ----------------------------------------
    // Transactions
    // ----------------------------------------
    task automatic write_burst(input bus_addr_t addr, input int count);
        bus_data_t data_q[$];
        bus_data_t value;
        logic      ack_bit;
        wr_addr_q.delete();
        wr_data_q.delete();
        issue_start();
        send_byte({DEVICE_ID, 1'b0}, ack_bit);
        check_value("sda ack after device address", ack_bit, ACK_LEVEL);
        send_byte(addr, ack_bit);
        check_value("sda ack after register address", ack_bit, ACK_LEVEL);
        for (int i = 0; i < count; i++)
        begin
            value = bus_data_t'($random(seed));
            data_q.push_back(value);
            send_byte(value, ack_bit);
            check_value("sda ack after write data", ack_bit, ACK_LEVEL);
        end
        issue_stop();
        check_idle();
        // One bus write per byte, in order, at consecutive addresses
        check_value("o_bus_wr pulse count", wr_addr_q.size(), count);
        for (int i = 0; i < count; i++)
        begin
            check_value("o_bus_addr", wr_addr_q[i], bus_addr_t'(addr + i));
            check_value("o_bus_data", wr_data_q[i], data_q[i]);
        end
    endtask

    // Register address written first, then repeated START and read
    task automatic read_burst(input bus_addr_t addr, input int count);
        bus_data_t value;
        bus_addr_t rd_addr;
        logic      ack_bit;
        wr_addr_q.delete();
        issue_start();
        send_byte({DEVICE_ID, 1'b0}, ack_bit);
        check_value("sda ack after device address", ack_bit, ACK_LEVEL);
        send_byte(addr, ack_bit);
        check_value("sda ack after register address", ack_bit, ACK_LEVEL);
        issue_start();
        send_byte({DEVICE_ID, 1'b1}, ack_bit);
        check_value("sda ack after read address", ack_bit, ACK_LEVEL);
        rd_addr = addr;
        for (int i = 0; i < count; i++)
        begin
            // Last byte is NACKed
            recv_byte((i == count - 1) ? NACK_LEVEL : ACK_LEVEL, value);
            check_value("read data on sda", value, mem[rd_addr]);
            rd_addr = rd_addr + 1'b1;
        end
        issue_stop();
        check_idle();
        check_value("o_bus_wr pulses during read", wr_addr_q.size(), 0);
    endtask

    task automatic wrong_address();
        logic [6:0] dev_id;
        logic       rw_bit;
        logic       ack_bit;
        dev_id = 7'($random(seed));
        while (dev_id == DEVICE_ID)
            dev_id = 7'($random(seed));
        rw_bit   = 1'($random(seed));
        bus_seen = 1'b0;
        issue_start();
        send_byte({dev_id, rw_bit}, ack_bit);
        check_value("sda nack after wrong address", ack_bit, NACK_LEVEL);
        issue_stop();
        check_value("o_bus_cs raised on wrong address", bus_seen, 1'b0);
        check_idle();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        bus_addr_t addr;
        int        count;
        seed       = 32'h49bd;
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_scl      = 1'b1;
        sda_drive  = 1'b1;
        i_bus_data = '0;
        bus_seen   = 1'b0;
        for (int a = 0; a < 256; a++)
            mem[a] = bus_data_t'((a * 37) ^ 8'h96);
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;
        check_idle();
        check_value("o_bus_addr after reset", o_bus_addr, 0);
        check_value("o_bus_data after reset", o_bus_data, 0);
        wait_clocks(QUARTER_SCL);
        for (int r = 0; r < NUM_ROUNDS; r++)
        begin
            addr  = bus_addr_t'($random(seed));
            count = 1 + int'($unsigned($random(seed)) % MAX_BYTES);
            write_burst(addr, count);
            count = 1 + int'($unsigned($random(seed)) % MAX_BYTES);
            read_burst(addr, count);
            wrong_address();
        end
        if (uut.u_sva.fail_count == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            $display("Test failed");
            $fatal(1, "Assertion failure");
        end
    end

endmodule

//--- dv/i2c_slave_sva.sv
// Bound checks on the bus strobes and the open-drain SDA drive of i2c_slave_top
// The SCL high window is counted on the raw SCL input

module i2c_slave_sva
(
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_scl,
    input logic                 i_sda_oe,
    input logic                 i_bus_cs,
    input logic                 i_bus_wr,
    input i2c_pkg::xfer_state_t i_state
);

    import i2c_pkg::*;

    // Read by the testbench to stop on a failure
    int   fail_count = 0;
    int   scl_high_cnt;
    logic slave_bit;

    // Consecutive high SCL samples, saturating at the filter depth
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
            scl_high_cnt <= 0;
        else if (!i_scl)
            scl_high_cnt <= 0;
        else if (scl_high_cnt < FILTER_DEPTH)
            scl_high_cnt <= scl_high_cnt + 1;
    end

    // Slave owns SDA during ACK bits and read data bits
    always_comb
    begin
        slave_bit = (i_state == st_ack_dev) || (i_state == st_ack_reg)
                 || (i_state == st_ack_wr) || (i_state == st_rd_data);
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    wr_implies_cs: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_wr |-> i_bus_cs)
    else
    begin
        fail_count = fail_count + 1;
        $error("bus write strobe without chip select");
    end

    wr_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_wr |=> !i_bus_wr)
    else
    begin
        fail_count = fail_count + 1;
        $error("bus write strobe held for two cycles");
    end

    sda_only_in_slave_bits: assert property (@(posedge i_clk) disable iff (i_reset)
        ((scl_high_cnt == FILTER_DEPTH) && i_sda_oe) |-> slave_bit)
    else
    begin
        fail_count = fail_count + 1;
        $error("SDA pulled low during SCL high outside an ACK or read bit");
    end

endmodule

bind i2c_slave_top i2c_slave_sva u_sva
(
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_scl    (i_scl),
    .i_sda_oe (o_sda_oe),
    .i_bus_cs (o_bus_cs),
    .i_bus_wr (o_bus_wr),
    .i_state  (state)
);

//--- source/i2c_slave_top.sv
// I2C slave to internal register bus bridge, device address fixed in i2c_pkg
// SDA arrives as a plain input, the open-drain pad is driven from o_sda_oe outside

module i2c_slave_top
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_scl,
    input  logic               i_sda,
    input  bus_pkg::bus_data_t i_bus_data,
    output logic               o_sda_oe,
    output logic               o_bus_cs,
    output logic               o_bus_wr,
    output bus_pkg::bus_addr_t o_bus_addr,
    output bus_pkg::bus_data_t o_bus_data
);

    // Filtered line events
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic scl_fall_late;
    logic sda;

    // Controller handshake
    i2c_pkg::xfer_state_t state;
    bus_pkg::bus_data_t   rx_byte;
    logic                 byte_done;
    logic                 send_done;
    logic                 dev_match;
    logic                 addr_load;
    logic                 addr_incr;
    logic                 data_load;

    i2c_line_sampler u_sampler
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_scl           (i_scl),
        .i_sda           (i_sda),
        .o_start         (start),
        .o_stop          (stop),
        .o_scl_rise      (scl_rise),
        .o_scl_fall      (scl_fall),
        .o_scl_fall_late (scl_fall_late),
        .o_sda           (sda)
    );

    i2c_byte_receiver u_receiver
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_state     (state),
        .i_scl_rise  (scl_rise),
        .i_sda       (sda),
        .o_byte      (rx_byte),
        .o_byte_done (byte_done)
    );

    // Read data comes straight from the bus
    i2c_sda_driver u_driver
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_state         (state),
        .i_dev_match     (dev_match),
        .i_scl_fall      (scl_fall),
        .i_scl_fall_late (scl_fall_late),
        .i_tx_data       (i_bus_data),
        .o_sda_oe        (o_sda_oe),
        .o_send_done     (send_done)
    );

    i2c_transfer_ctrl u_ctrl
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (start),
        .i_stop      (stop),
        .i_byte_done (byte_done),
        .i_byte      (rx_byte),
        .i_send_done (send_done),
        .o_state     (state),
        .o_dev_match (dev_match),
        .o_addr_load (addr_load),
        .o_addr_incr (addr_incr),
        .o_data_load (data_load)
    );

    reg_bus_master u_bus
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_state     (state),
        .i_byte      (rx_byte),
        .i_addr_load (addr_load),
        .i_addr_incr (addr_incr),
        .i_data_load (data_load),
        .o_bus_cs    (o_bus_cs),
        .o_bus_wr    (o_bus_wr),
        .o_bus_addr  (o_bus_addr),
        .o_bus_data  (o_bus_data)
    );

endmodule

//--- source/reg_bus_master.sv
// Register address counter and strobes for the SRAM-like internal bus
// Read data must stay valid on the bus for the whole rd_data byte

module reg_bus_master
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  i2c_pkg::xfer_state_t i_state,
    input  bus_pkg::bus_data_t   i_byte,
    input  logic                 i_addr_load,
    input  logic                 i_addr_incr,
    input  logic                 i_data_load,
    output logic                 o_bus_cs,
    output logic                 o_bus_wr,
    output bus_pkg::bus_addr_t   o_bus_addr,
    output bus_pkg::bus_data_t   o_bus_data
);

    import i2c_pkg::*;

    // Write already issued for the current ACK bit
    logic wr_done;

    // Address counter and write data latch
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            o_bus_addr <= '0;
            o_bus_data <= '0;
        end
        else
        begin
            if (i_addr_load)
                o_bus_addr <= i_byte;
            else if (i_addr_incr)
                o_bus_addr <= o_bus_addr + 1'b1;
            if (i_data_load)
                o_bus_data <= i_byte;
        end
    end

    // ----------------------------------------
    // Select and write strobes
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            o_bus_cs <= 1'b0;
            o_bus_wr <= 1'b0;
            wr_done  <= 1'b0;
        end
        else if (i_state == st_ack_wr)
        begin
            // One write cycle per received byte
            o_bus_cs <= !wr_done;
            o_bus_wr <= !wr_done;
            wr_done  <= 1'b1;
        end
        else
        begin
            o_bus_cs <= (i_state == st_rd_data);
            o_bus_wr <= 1'b0;
            wr_done  <= 1'b0;
        end
    end

endmodule

//--- source/i2c_transfer_ctrl.sv
// Transaction FSM for writes and combined write-address-then-read transfers
// Repeated START or STOP is honoured only during the write phase

module i2c_transfer_ctrl
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  logic                 i_stop,
    input  logic                 i_byte_done,
    input  bus_pkg::bus_data_t   i_byte,
    input  logic                 i_send_done,
    output i2c_pkg::xfer_state_t o_state,
    output logic                 o_dev_match,
    output logic                 o_addr_load,
    output logic                 o_addr_incr,
    output logic                 o_data_load
);

    import i2c_pkg::*;

    logic dev_read;

    // ----------------------------------------
    // Main FSM
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            o_state <= st_idle;
        end
        else
        begin
            case (o_state)
            st_idle:
            begin
                if (i_start)
                    o_state <= st_start;
            end
            st_start:
            begin
                o_state <= st_dev_addr;
            end
            st_dev_addr:
            begin
                if (i_byte_done)
                    o_state <= st_ack_dev;
            end
            st_ack_dev:
            begin
                // NACKed address drops back to idle
                if (i_send_done)
                    o_state <= !o_dev_match ? st_idle : (dev_read ? st_rd_data : st_reg_addr);
            end
            st_reg_addr:
            begin
                if (i_byte_done)
                    o_state <= st_ack_reg;
            end
            st_ack_reg:
            begin
                if (i_send_done)
                    o_state <= st_wr_data;
            end
            st_wr_data, st_ack_wr:
            begin
                if (i_stop)
                    o_state <= st_idle;
                else if (i_start)
                    o_state <= st_start;
                else if (i_byte_done && (o_state == st_wr_data))
                    o_state <= st_ack_wr;
                else if (i_send_done && (o_state == st_ack_wr))
                    o_state <= st_wr_data;
            end
            st_rd_data:
            begin
                if (i_send_done)
                    o_state <= st_master_ack;
            end
            st_master_ack:
            begin
                // Master NACK ends the read
                if (i_byte_done)
                    o_state <= (i_byte[0] == ACK_LEVEL) ? st_rd_data : st_idle;
            end
            default:
            begin
                o_state <= st_idle;
            end
            endcase
        end
    end

    // Address match and R/W bit of the first byte
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            o_dev_match <= 1'b0;
            dev_read    <= 1'b0;
        end
        else if ((o_state == st_dev_addr) && i_byte_done)
        begin
            o_dev_match <= (i_byte[7:1] == DEVICE_ID);
            dev_read    <= i_byte[0];
        end
        else if ((o_state == st_idle) || (o_state == st_start))
        begin
            o_dev_match <= 1'b0;
            dev_read    <= 1'b0;
        end
    end

    // ----------------------------------------
    // Bus master strobes
    // ----------------------------------------
    always_comb
    begin
        o_addr_load = (o_state == st_reg_addr) && i_byte_done;
        o_data_load = (o_state == st_wr_data) && i_byte_done;
        // Step after each written byte and after each master ACK or NACK
        o_addr_incr = ((o_state == st_ack_wr) && i_send_done)
                   || ((o_state == st_master_ack) && i_byte_done);
    end

endmodule

//--- source/i2c_sda_driver.sv
// Drives ACK, NACK and read data onto an open-drain SDA, o_sda_oe high pulls the line low
// The pad and its pull-up live outside this design

module i2c_sda_driver
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  i2c_pkg::xfer_state_t i_state,
    input  logic                 i_dev_match,
    input  logic                 i_scl_fall,
    input  logic                 i_scl_fall_late,
    input  bus_pkg::bus_data_t   i_tx_data,
    output logic                 o_sda_oe,
    output logic                 o_send_done
);

    import i2c_pkg::*;

    sda_state_t           sda_state;
    logic [BIT_CNT_W-1:0] bit_idx;
    logic                 ack_state;
    logic                 ack_level;

    always_comb
    begin
        ack_state = (i_state == st_ack_dev) || (i_state == st_ack_reg)
                 || (i_state == st_ack_wr);
        // Only the device address phase may answer NACK
        ack_level = ((i_state != st_ack_dev) || i_dev_match) ? ACK_LEVEL : NACK_LEVEL;
    end

    // ----------------------------------------
    // SDA output FSM
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            sda_state   <= sda_recv;
            bit_idx     <= LAST_BIT;
            o_sda_oe    <= 1'b0;
            o_send_done <= 1'b0;
        end
        else if ((i_state == st_idle) || (i_state == st_start))
        begin
            // START or STOP mid-bit, let go of the line at once
            sda_state   <= sda_recv;
            bit_idx     <= LAST_BIT;
            o_sda_oe    <= 1'b0;
            o_send_done <= 1'b0;
        end
        else
        begin
            case (sda_state)
            sda_recv:
            begin
                o_send_done <= 1'b0;
                bit_idx     <= LAST_BIT;
                // Done pulse blocks a rearm before the controller moves on
                if (!o_send_done && (ack_state || (i_state == st_rd_data)))
                begin
                    sda_state <= sda_arm;
                end
            end

            sda_arm:
            begin
                o_send_done <= 1'b0;
                if (ack_state && i_scl_fall)
                begin
                    o_sda_oe  <= ~ack_level;
                    sda_state <= sda_send_wait;
                end
                else if ((i_state == st_rd_data) && i_scl_fall_late)
                begin
                    // MSB goes out well after the fall for hold time
                    o_sda_oe  <= ~i_tx_data[bit_idx];
                    bit_idx   <= bit_idx - 1'b1;
                    sda_state <= sda_send_data;
                end
            end

            sda_send_data:
            begin
                if (i_scl_fall)
                begin
                    o_sda_oe <= ~i_tx_data[bit_idx];
                    if (bit_idx == '0)
                    begin
                        sda_state <= sda_send_wait;
                    end
                    else
                    begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
            end

            sda_send_wait:
            begin
                // Hold the last bit for one full SCL period
                if (i_scl_fall)
                begin
                    o_sda_oe    <= 1'b0;
                    o_send_done <= 1'b1;
                    sda_state   <= sda_recv;
                end
            end

            default:
            begin
                sda_state <= sda_recv;
            end
            endcase
        end
    end

endmodule

//--- source/i2c_byte_receiver.sv
// Shifts SDA in MSB first on each filtered SCL rise
// In master_ack only one bit is taken, into bit 0 of o_byte

module i2c_byte_receiver
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  i2c_pkg::xfer_state_t i_state,
    input  logic                i_scl_rise,
    input  logic                i_sda,
    output bus_pkg::bus_data_t  o_byte,
    output logic                o_byte_done
);

    import i2c_pkg::*;
    import bus_pkg::*;

    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 shift_state;
    logic                 clear_state;

    // States in which the master sends a full byte
    always_comb
    begin
        shift_state = (i_state == st_dev_addr) || (i_state == st_reg_addr)
                   || (i_state == st_wr_data);
    end

    // Slave owns SDA or no transfer is running
    always_comb
    begin
        clear_state = (i_state == st_idle) || (i_state == st_start)
                   || (i_state == st_rd_data) || (i_state == st_ack_dev)
                   || (i_state == st_ack_reg) || (i_state == st_ack_wr);
    end

    // ----------------------------------------
    // Bit counter and done pulse
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            bit_cnt     <= '0;
            o_byte_done <= 1'b0;
        end
        else if (clear_state)
        begin
            bit_cnt     <= '0;
            o_byte_done <= 1'b0;
        end
        else if (i_scl_rise && shift_state)
        begin
            if (bit_cnt == LAST_BIT)
            begin
                bit_cnt     <= '0;
                o_byte_done <= 1'b1;
            end
            else
            begin
                bit_cnt     <= bit_cnt + 1'b1;
                o_byte_done <= 1'b0;
            end
        end
        else if (i_scl_rise && (i_state == st_master_ack))
        begin
            // Single acknowledge bit from the master
            bit_cnt     <= '0;
            o_byte_done <= 1'b1;
        end
        else
        begin
            o_byte_done <= 1'b0;
        end
    end

    // Shift register
    always_ff @(posedge i_clk)
    begin
        if (i_scl_rise && shift_state)
        begin
            o_byte <= {o_byte[BUS_DATA_W-2:0], i_sda};
        end
        else if (i_scl_rise && (i_state == st_master_ack))
        begin
            o_byte[0] <= i_sda;
        end
    end

endmodule

//--- source/i2c_line_sampler.sv
// SCL and SDA filter with START, STOP and SCL edge detection
// Inputs are assumed synchronous enough to i_clk; glitches under FILTER_DEPTH clocks are dropped

module i2c_line_sampler
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_scl,
    input  logic i_sda,
    output logic o_start,
    output logic o_stop,
    output logic o_scl_rise,
    output logic o_scl_fall,
    output logic o_scl_fall_late,
    output logic o_sda
);

    import i2c_pkg::*;

    // Sample histories, newest sample in bit 0
    filter_t scl_hist;
    filter_t sda_hist;

    // ----------------------------------------
    // Sample histories
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            // Released bus reads high on both lines
            scl_hist <= '1;
            sda_hist <= '1;
        end
        else
        begin
            scl_hist <= {scl_hist[FILTER_DEPTH-2:0], i_scl};
            sda_hist <= {sda_hist[FILTER_DEPTH-2:0], i_sda};
        end
    end

    // ----------------------------------------
    // Pattern match strobes
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            o_start         <= 1'b0;
            o_stop          <= 1'b0;
            o_scl_rise      <= 1'b0;
            o_scl_fall      <= 1'b0;
            o_scl_fall_late <= 1'b0;
        end
        else
        begin
            // SDA moves while SCL held high
            o_start         <= (sda_hist == START_SDA_PAT) && (scl_hist == SCL_HIGH_PAT);
            o_stop          <= (sda_hist == STOP_SDA_PAT) && (scl_hist == SCL_HIGH_PAT);
            o_scl_rise      <= (scl_hist == SCL_RISE_PAT);
            o_scl_fall      <= (scl_hist == SCL_FALL_PAT);
            o_scl_fall_late <= (scl_hist == SCL_FALL_LATE_PAT);
        end
    end

    assign o_sda = sda_hist[0];

endmodule

//--- source/bus_pkg.sv
// Internal register bus widths, an asynchronous SRAM-like port
// Address and data are both one byte wide, one I2C byte per bus word

package bus_pkg;

    localparam int BUS_ADDR_W = 8;
    localparam int BUS_DATA_W = 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

endpackage

//--- source/i2c_pkg.sv
// I2C protocol constants, filter patterns and state encodings
// The filter patterns assume the newest sample sits in bit 0 of a history

package i2c_pkg;

    // ----------------------------------------
    // Protocol constants
    // ----------------------------------------
    localparam logic [6:0] DEVICE_ID     = 7'h08;
    localparam int         BITS_PER_BYTE = 8;
    localparam logic       ACK_LEVEL     = 1'b0;
    localparam logic       NACK_LEVEL    = 1'b1;

    // Bit counter shared by the receiver and the SDA driver
    localparam int                   BIT_CNT_W = $clog2(BITS_PER_BYTE);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT  = BIT_CNT_W'(BITS_PER_BYTE - 1);

    // ----------------------------------------
    // Line filter
    // ----------------------------------------
    localparam int FILTER_DEPTH = 8;

    typedef logic [FILTER_DEPTH-1:0] filter_t;

    // SDA falls or rises halfway through a window of steady high SCL
    localparam filter_t START_SDA_PAT = {{(FILTER_DEPTH/2){1'b1}}, {(FILTER_DEPTH/2){1'b0}}};
    localparam filter_t STOP_SDA_PAT  = {{(FILTER_DEPTH/2){1'b0}}, {(FILTER_DEPTH/2){1'b1}}};
    localparam filter_t SCL_HIGH_PAT  = {FILTER_DEPTH{1'b1}};
    // Edge points, late fall leaves SDA setup room before the next rise
    localparam filter_t SCL_RISE_PAT      = {1'b0, {(FILTER_DEPTH-1){1'b1}}};
    localparam filter_t SCL_FALL_PAT      = {{(FILTER_DEPTH-1){1'b1}}, 1'b0};
    localparam filter_t SCL_FALL_LATE_PAT = {2'b11, {(FILTER_DEPTH-2){1'b0}}};

    // ----------------------------------------
    // State encodings
    // ----------------------------------------
    typedef enum logic [3:0]
    {
        st_idle       = 4'h0,
        st_start      = 4'h1,
        st_dev_addr   = 4'h2,
        st_ack_dev    = 4'h3,
        st_reg_addr   = 4'h4,
        st_ack_reg    = 4'h5,
        st_wr_data    = 4'h6,
        st_ack_wr     = 4'h7,
        st_rd_data    = 4'h8,
        st_master_ack = 4'h9
    } xfer_state_t;

    typedef enum logic [1:0]
    {
        sda_recv      = 2'h0,
        sda_arm       = 2'h1,
        sda_send_data = 2'h2,
        sda_send_wait = 2'h3
    } sda_state_t;

endpackage
